// File: flist.f
source/calc_pkg.sv
source/add_sub_unit.sv
source/seq_multiplier.sv
source/calc_controller.sv
source/calculator_top.sv
test/tb_clock_gen.sv
test/calculator_asserts.sv
test/calculator_tb.sv

// File: Bender.yml
package:
  name: calculator

sources:
  - files:
      - source/calc_pkg.sv
      - source/add_sub_unit.sv
      - source/seq_multiplier.sv
      - source/calc_controller.sv
      - source/calculator_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/calculator_asserts.sv
      - test/calculator_tb.sv

// File: test/calculator_tb.sv
// Calculator testbench with random keypad sessions, junk strobes and a reference model

`timescale 1ns/1ps

module calculator_tb;

    import calc_pkg::*;

    localparam int unsigned SEED         = 32'h149d_1d93;
    localparam int unsigned NUM_SESSIONS = 24;
    localparam int unsigned RESET_CYCLES = 5;
    // Ten digits, operator, gaps, and a multiply as the slowest operation
    localparam int unsigned SESSION_MAX  = 10 * (MULT_CYCLES + 4) + MULT_CYCLES + 12;
    localparam int unsigned CYCLE_LIMIT  = NUM_SESSIONS * SESSION_MAX * 2 + RESET_CYCLES;

    logic     clk;
    logic     nRST;
    digit_t   keypad_input;
    logic     read_input;
    op_code_t operator_input;
    logic     equal_input;
    logic     complete;
    word_t    display_output;
    logic     busy;

    word_t       shown;
    int unsigned cycle_count = 0;

    tb_clock_gen i_clk_gen (
        .clk (clk)
    );

    calculator_top i_dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output),
        .busy           (busy)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped at %0t: sessions not done within %0d cycles", $time,
                     CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic word_t shift_in(input word_t value, input digit_t digit);
        logic [31:0] wide;
        wide = value * 32'd10 + digit;
        return wide[15:0];
    endfunction

    function automatic word_t model_result(input op_code_t op, input word_t a, input word_t b);
        logic [31:0] wide;
        case (op)
            OP_ADD:  wide = a + b;
            OP_SUB:  wide = a - b;
            default: wide = a * b;
        endcase
        return wide[15:0];
    endfunction

    // Display must hold the last result except in a complete cycle
    task automatic tick();
        @(posedge clk);
        #1;
        if (!complete) begin
            check_word("display_output", display_output, shown);
        end
    endtask

    task automatic idle_inputs();
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
    endtask

    // Strobes a busy controller has to ignore
    task automatic drive_junk();
        keypad_input   = digit_t'($urandom % 10);
        read_input     = ($urandom % 3) == 0;
        operator_input = op_code_t'($urandom);
        equal_input    = ($urandom % 3) == 0;
    endtask

    task automatic wait_ready();
        while (busy) begin
            drive_junk();
            tick();
        end
        idle_inputs();
        repeat ($urandom % 3) tick();
    endtask

    task automatic enter_digit(inout word_t operand, input digit_t digit);
        keypad_input = digit;
        read_input   = 1'b1;
        tick();
        // Busy until MULT_CYCLES + 2 cycles after the read
        for (int i = 0; i <= MULT_CYCLES; i++) begin
            check_bit("busy", busy, 1'b1);
            check_bit("complete", complete, 1'b0);
            drive_junk();
            tick();
        end
        idle_inputs();
        check_bit("busy", busy, 1'b0);
        operand = shift_in(operand, digit);
    endtask

    task automatic enter_operator(input op_code_t op);
        operator_input = op;
        tick();
        idle_inputs();
        check_bit("busy", busy, 1'b0);
    endtask

    task automatic press_equal(input word_t expected);
        equal_input = 1'b1;
        tick();
        idle_inputs();
        while (!complete) begin
            check_bit("busy", busy, 1'b1);
            drive_junk();
            tick();
        end
        check_bit("busy", busy, 1'b1);
        check_word("display_output", display_output, expected);
        shown = expected;
        drive_junk();
        tick();
        idle_inputs();
        check_bit("complete", complete, 1'b0);
        check_bit("busy", busy, 1'b0);
    endtask

    task automatic run_session(input int unsigned index);
        op_code_t    op;
        int unsigned na;
        int unsigned nb;
        word_t       a;
        word_t       b;
        digit_t      d;
        a = '0;
        b = '0;
        case (index % 3)
            0: begin
                op = OP_ADD;
                na = 1 + $urandom % 4;
                nb = 1 + $urandom % 4;
            end
            1: begin
                op = OP_SUB;
                na = 1 + $urandom % 3;
                nb = na + 1;
            end
            default: begin
                op = OP_MUL;
                na = (index % 6 == 2) ? 5 : 1 + $urandom % 5;
                nb = 1 + $urandom % 5;
            end
        endcase
        for (int i = 0; i < na; i++) begin
            wait_ready();
            enter_digit(a, digit_t'($urandom % 10));
        end
        wait_ready();
        enter_operator(op);
        for (int i = 0; i < nb; i++) begin
            // Extra digit with a nonzero lead puts b above a for a subtract
            d = (i == 0 && op == OP_SUB) ? digit_t'(1 + $urandom % 9) : digit_t'($urandom % 10);
            wait_ready();
            enter_digit(b, d);
        end
        wait_ready();
        press_equal(model_result(op, a, b));
    endtask

    initial begin
        int unsigned assert_fails;
        void'($urandom(SEED));
        nRST  = 1'b0;
        shown = '0;
        idle_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nRST = 1'b1;
        check_word("display_output", display_output, 16'h0000);
        check_bit("complete", complete, 1'b0);
        check_bit("busy", busy, 1'b0);
        for (int s = 0; s < NUM_SESSIONS; s++) begin
            run_session(s);
        end
        repeat (4) tick();
        assert_fails = i_dut.i_controller.i_asserts.fail_count;
        if (assert_fails == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("Concurrent assertions failed %0d times", assert_fails);
            $display("SIMULATION FAILED");
            $fatal(1, "concurrent assertion failure");
        end
    end

endmodule

// File: test/calculator_asserts.sv
// Concurrent checks on controller start, finish and complete strobes, plus their bind

`timescale 1ns/1ps

module calculator_asserts (
    input logic clk,
    input logic nRST,
    input logic alu_start,
    input logic alu_finish,
    input logic mult_start,
    input logic mult_finish,
    input logic complete
);

    import calc_pkg::*;

    int unsigned fail_count = 0;

    mult_latency: assert property (@(posedge clk) disable iff (!nRST)
        mult_start |-> ##MULT_CYCLES mult_finish)
        else begin
            fail_count++;
            $error("mult_finish missing %0d cycles after mult_start", MULT_CYCLES);
        end

    alu_latency: assert property (@(posedge clk) disable iff (!nRST)
        alu_start |=> alu_finish)
        else begin
            fail_count++;
            $error("alu_finish missing one cycle after alu_start");
        end

    complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else begin
            fail_count++;
            $error("complete held for more than one cycle");
        end

    // Only one unit may be started per cycle
    start_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        !(alu_start && mult_start))
        else begin
            fail_count++;
            $error("alu_start and mult_start high in the same cycle");
        end

endmodule

bind calc_controller calculator_asserts i_asserts (
    .clk         (clk),
    .nRST        (nRST),
    .alu_start   (alu_start),
    .alu_finish  (alu_finish),
    .mult_start  (mult_start),
    .mult_finish (mult_finish),
    .complete    (complete)
);

// File: test/tb_clock_gen.sv
// Free-running testbench clock with a 4 ns period

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam realtime HALF_PERIOD = 2.0;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

// File: source/calculator_top.sv
// Calculator top level with controller, adder/subtractor and multiplier

`timescale 1ns/1ps

module calculator_top (
    input  logic               clk,
    input  logic               nRST,
    input  calc_pkg::digit_t   keypad_input,
    input  logic               read_input,
    input  calc_pkg::op_code_t operator_input,
    input  logic               equal_input,
    output logic               complete,
    output calc_pkg::word_t    display_output,
    output logic               busy
);

    import calc_pkg::*;

    unit_req_t alu_req;
    unit_req_t mult_req;
    word_t     alu_result;
    word_t     mult_result;
    logic      alu_start;
    logic      alu_finish;
    logic      mult_start;
    logic      mult_finish;

    calc_controller i_controller (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .alu_req        (alu_req),
        .alu_start      (alu_start),
        .alu_result     (alu_result),
        .alu_finish     (alu_finish),
        .mult_req       (mult_req),
        .mult_start     (mult_start),
        .mult_result    (mult_result),
        .mult_finish    (mult_finish),
        .complete       (complete),
        .display_output (display_output),
        .busy           (busy)
    );

    add_sub_unit i_add_sub (
        .clk    (clk),
        .nRST   (nRST),
        .req    (alu_req),
        .start  (alu_start),
        .result (alu_result),
        .finish (alu_finish)
    );

    seq_multiplier i_mult (
        .clk    (clk),
        .nRST   (nRST),
        .req    (mult_req),
        .start  (mult_start),
        .result (mult_result),
        .finish (mult_finish)
    );

endmodule

// File: source/calc_controller.sv
// Keypad entry and operation FSM that builds operands and dispatches to the two units

`timescale 1ns/1ps

module calc_controller (
    input  logic                clk,
    input  logic                nRST,
    input  calc_pkg::digit_t    keypad_input,
    input  logic                read_input,
    input  calc_pkg::op_code_t  operator_input,
    input  logic                equal_input,
    output calc_pkg::unit_req_t alu_req,
    output logic                alu_start,
    input  calc_pkg::word_t     alu_result,
    input  logic                alu_finish,
    output calc_pkg::unit_req_t mult_req,
    output logic                mult_start,
    input  calc_pkg::word_t     mult_result,
    input  logic                mult_finish,
    output logic                complete,
    output calc_pkg::word_t     display_output,
    output logic                busy
);

    import calc_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    word_t    operand_a;
    word_t    operand_b;
    word_t    shift_operand;
    word_t    unit_result;
    digit_t   digit_lat;
    op_code_t op_reg;

    logic digit_seen;
    logic entry_state;
    logic operand_b_phase;
    logic run_phase;
    logic op_valid;
    logic digit_take;
    logic op_take;
    logic equal_take;
    logic use_mult;
    logic unit_finish;

    assign entry_state     = (state == ENTRY_A) || (state == ENTRY_B);
    assign operand_b_phase = state inside {ENTRY_B, SHIFT_B, ADD_DIGIT_B};
    assign run_phase       = state inside {DISPATCH, WAIT_UNIT};
    assign op_valid        = operator_input inside {OP_ADD, OP_SUB, OP_MUL};

    // Digit strobe wins over operator or equal in the same cycle
    assign digit_take = entry_state && read_input;
    assign op_take    = (state == ENTRY_A) && !read_input && digit_seen && op_valid;
    assign equal_take = (state == ENTRY_B) && !read_input && digit_seen && equal_input;

    assign busy     = !entry_state;
    assign complete = (state == SHOW);

    assign use_mult      = (op_reg == OP_MUL);
    assign shift_operand = operand_b_phase ? operand_b : operand_a;

    // Digit shift starts in the strobe cycle so entry returns after MULT_CYCLES + 2
    assign mult_start = digit_take || ((state == DISPATCH) && use_mult);
    assign alu_start  = (state == DISPATCH) && !use_mult;

    assign mult_req.a   = run_phase ? operand_a : shift_operand;
    assign mult_req.b   = run_phase ? operand_b : DECIMAL_BASE;
    assign mult_req.sub = 1'b0;

    assign alu_req.a   = operand_a;
    assign alu_req.b   = operand_b;
    assign alu_req.sub = (op_reg == OP_SUB);

    assign unit_finish = use_mult ? mult_finish : alu_finish;
    assign unit_result = use_mult ? mult_result : alu_result;

    always_comb begin
        next_state = state;
        case (state)
            ENTRY_A: begin
                if (digit_take) begin
                    next_state = SHIFT_A;
                end else if (op_take) begin
                    next_state = ENTRY_B;
                end
            end
            SHIFT_A: begin
                if (mult_finish) begin
                    next_state = ADD_DIGIT_A;
                end
            end
            ADD_DIGIT_A: next_state = ENTRY_A;
            ENTRY_B: begin
                if (digit_take) begin
                    next_state = SHIFT_B;
                end else if (equal_take) begin
                    next_state = DISPATCH;
                end
            end
            SHIFT_B: begin
                if (mult_finish) begin
                    next_state = ADD_DIGIT_B;
                end
            end
            ADD_DIGIT_B: next_state = ENTRY_B;
            DISPATCH:    next_state = WAIT_UNIT;
            WAIT_UNIT: begin
                if (unit_finish) begin
                    next_state = SHOW;
                end
            end
            SHOW:    next_state = ENTRY_A;
            default: next_state = ENTRY_A;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTRY_A;
            operand_a      <= '0;
            operand_b      <= '0;
            op_reg         <= '0;
            digit_seen     <= 1'b0;
            display_output <= '0;
        end else begin
            state <= next_state;
            if (digit_take) begin
                digit_seen <= 1'b1;
            end
            // Second operand needs its own digit
            if (op_take) begin
                op_reg     <= operator_input;
                digit_seen <= 1'b0;
            end
            case (state)
                SHIFT_A: begin
                    if (mult_finish) begin
                        operand_a <= mult_result;
                    end
                end
                ADD_DIGIT_A: operand_a <= operand_a + word_t'(digit_lat);
                SHIFT_B: begin
                    if (mult_finish) begin
                        operand_b <= mult_result;
                    end
                end
                ADD_DIGIT_B: operand_b <= operand_b + word_t'(digit_lat);
                WAIT_UNIT: begin
                    if (unit_finish) begin
                        display_output <= unit_result;
                    end
                end
                SHOW: begin
                    operand_a  <= '0;
                    operand_b  <= '0;
                    digit_seen <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // Digit held until the shifted operand is ready
    always_ff @(posedge clk) begin
        if (digit_take) begin
            digit_lat <= keypad_input;
        end
    end

endmodule

// File: source/seq_multiplier.sv
// Shift-and-add 16-bit multiplier, one multiplier bit per cycle, fixed latency

`timescale 1ns/1ps

module seq_multiplier (
    input  logic                clk,
    input  logic                nRST,
    input  calc_pkg::unit_req_t req,
    input  logic                start,
    output calc_pkg::word_t     result,
    output logic                finish
);

    import calc_pkg::*;

    // One load cycle plus sixteen iterations, finish in the cycle after the last
    localparam int unsigned ITER_LAST = MULT_CYCLES - 2;
    localparam int unsigned CNT_W     = $clog2(ITER_LAST + 1);

    logic             active;
    logic [CNT_W-1:0] iter;
    logic             load;
    logic             last_iter;
    word_t            mcand;
    word_t            mplier;
    word_t            acc;

    // Start while an operation runs is dropped
    assign load      = start && !active;
    assign last_iter = active && (iter == CNT_W'(ITER_LAST));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            iter   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= last_iter;
            if (load) begin
                active <= 1'b1;
                iter   <= '0;
            end else if (active) begin
                iter <= iter + 1'b1;
                if (last_iter) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Only the low 16 bits of each partial product are kept
    always_ff @(posedge clk) begin
        if (load) begin
            mcand  <= req.a;
            mplier <= req.b;
            acc    <= '0;
        end else if (active) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Holds the last product until the next load
    assign result = acc;

endmodule

// File: source/add_sub_unit.sv
// Registered 16-bit adder/subtractor with one-cycle start-to-finish latency

`timescale 1ns/1ps

module add_sub_unit (
    input  logic                clk,
    input  logic                nRST,
    input  calc_pkg::unit_req_t req,
    input  logic                start,
    output calc_pkg::word_t     result,
    output logic                finish
);

    // Finish strobe trails start by exactly one cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    // Wraps modulo 2^16 in both modes
    always_ff @(posedge clk) begin
        if (start) begin
            if (req.sub) begin
                result <= req.a - req.b;
            end else begin
                result <= req.a + req.b;
            end
        end
    end

endmodule

// File: source/calc_pkg.sv
// Shared widths, value types, operator codes, unit request struct and controller states

package calc_pkg;

    localparam int unsigned WORD_W  = 16;
    localparam int unsigned DIGIT_W = 4;
    localparam int unsigned OP_W    = 3;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [DIGIT_W-1:0] digit_t;
    typedef logic [OP_W-1:0]    op_code_t;

    // One-hot operator codes, anything else is ignored
    localparam op_code_t OP_ADD = 3'b001;
    localparam op_code_t OP_SUB = 3'b010;
    localparam op_code_t OP_MUL = 3'b100;

    // Start-to-finish latency of the shift-and-add multiplier
    localparam int unsigned MULT_CYCLES = 17;

    // Multiplier operand for shifting in one decimal digit
    localparam word_t DECIMAL_BASE = 16'd10;

    typedef struct packed {
        word_t a;
        word_t b;
        logic  sub;
    } unit_req_t;

    typedef enum logic [3:0] {
        ENTRY_A,
        SHIFT_A,
        ADD_DIGIT_A,
        ENTRY_B,
        SHIFT_B,
        ADD_DIGIT_B,
        DISPATCH,
        WAIT_UNIT,
        SHOW
    } ctrl_state_t;

endpackage
